// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator from list.f and run the simulation"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_eth_axis_tx_64 -Mdir obj_dir -f list.f
	@out="$$(./obj_dir/Vtb_eth_axis_tx_64)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

// File: eth_axis_tx_64.sv
// top level of the 64-bit ethernet frame transmitter
`timescale 1ns/1ps

module eth_axis_tx_64 (
    input  logic                      clk,
    input  logic                      rst,
    input  eth_frame_pkg::eth_hdr_t   hdr,
    input  logic                      hdr_valid,
    output logic                      hdr_ready,
    input  eth_frame_pkg::axis_beat_t in_beat,
    input  logic                      in_valid,
    output logic                      in_ready,
    output eth_frame_pkg::axis_beat_t out_beat,
    output logic                      out_valid,
    input  logic                      out_ready,
    output logic                      busy
);

    eth_tx_ctrl_pkg::tx_cmd_t       cmd;
    eth_tx_ctrl_pkg::realign_stat_t stat;
    eth_frame_pkg::axis_beat_t      hdr_first;
    eth_frame_pkg::axis_beat_t      hdr_second;
    eth_frame_pkg::axis_beat_t      shifted;
    eth_frame_pkg::axis_beat_t      tail;
    logic                           temp_last;

    eth_tx_fsm u_fsm (
        .clk       (clk),
        .rst       (rst),
        .hdr_valid (hdr_valid),
        .hdr_ready (hdr_ready),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_last   (in_beat.last),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .stat      (stat),
        .temp_last (temp_last),
        .busy      (busy),
        .cmd       (cmd)
    );

    eth_hdr_builder u_hdr (
        .clk        (clk),
        .rst        (rst),
        .cmd        (cmd),
        .hdr        (hdr),
        .in_beat    (in_beat),
        .hdr_first  (hdr_first),
        .hdr_second (hdr_second)
    );

    eth_payload_realign u_realign (
        .clk     (clk),
        .rst     (rst),
        .cmd     (cmd),
        .in_beat (in_beat),
        .shifted (shifted),
        .tail    (tail),
        .stat    (stat)
    );

    eth_tx_out_stage u_out (
        .clk        (clk),
        .rst        (rst),
        .cmd        (cmd),
        .hdr_first  (hdr_first),
        .hdr_second (hdr_second),
        .shifted    (shifted),
        .tail       (tail),
        .out_beat   (out_beat),
        .temp_last  (temp_last)
    );

endmodule

// File: eth_frame_pkg.sv
// ethernet frame header fields, stream beat type and byte-lane constants
package eth_frame_pkg;

    // byte lanes in one 64-bit beat
    localparam int DATA_BYTES = 8;

    // destination mac, source mac and ethertype
    localparam int HDR_BYTES = 14;

    // payload lanes displaced by the header tail in the second word
    localparam int SHIFT_BYTES = 2 * DATA_BYTES - HDR_BYTES;

    typedef logic [47:0] mac_addr_t;

    typedef logic [15:0] eth_type_t;

    // fields are held most significant byte first, as they go on the wire
    typedef struct packed {
        mac_addr_t dest_mac;
        mac_addr_t src_mac;
        eth_type_t eth_type;
    } eth_hdr_t;

    // one stream beat, lane 0 in data[7:0] is the first byte on the wire
    typedef struct packed {
        logic [DATA_BYTES*8-1:0] data;
        logic [DATA_BYTES-1:0]   keep;
        logic                    last;
        logic                    user;
    } axis_beat_t;

endpackage

// File: eth_hdr_builder.sv
// header register and assembly of the two header output words
`timescale 1ns/1ps

module eth_hdr_builder (
    input  logic                     clk,
    input  logic                     rst,
    input  eth_tx_ctrl_pkg::tx_cmd_t cmd,
    input  eth_frame_pkg::eth_hdr_t  hdr,
    input  eth_frame_pkg::axis_beat_t in_beat,
    output eth_frame_pkg::axis_beat_t hdr_first,
    output eth_frame_pkg::axis_beat_t hdr_second
);

    localparam int NB = eth_frame_pkg::DATA_BYTES;
    localparam int SB = eth_frame_pkg::SHIFT_BYTES;

    eth_frame_pkg::eth_hdr_t hdr_q;

    logic in_end;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hdr_q <= '0;
        end else if (cmd.store_hdr) begin
            hdr_q <= hdr;
        end
    end

    // final beat whose bytes all fit beside the header tail
    assign in_end = in_beat.last && (in_beat.keep[NB-1:SB] == '0);

    // first word straight from the header being accepted
    always_comb begin
        for (int i = 0; i < 6; i++) begin
            hdr_first.data[8*i +: 8] = hdr.dest_mac[8*(5-i) +: 8];
        end
        hdr_first.data[55:48] = hdr.src_mac[47:40];
        hdr_first.data[63:56] = hdr.src_mac[39:32];
        hdr_first.keep        = '1;
        hdr_first.last        = 1'b0;
        hdr_first.user        = 1'b0;
    end

    // rest of the source mac, ethertype, then the first payload bytes
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            hdr_second.data[8*i +: 8] = hdr_q.src_mac[8*(3-i) +: 8];
        end
        hdr_second.data[39:32]       = hdr_q.eth_type[15:8];
        hdr_second.data[47:40]       = hdr_q.eth_type[7:0];
        hdr_second.data[8*NB-1:48]   = in_beat.data[8*SB-1:0];
        hdr_second.keep              = {in_beat.keep[SB-1:0], 6'h3f};
        hdr_second.last              = in_end;
        hdr_second.user              = in_beat.user && in_end;
    end

endmodule

// File: eth_payload_realign.sv
// payload save register and two-byte realignment of payload beats
`timescale 1ns/1ps

module eth_payload_realign (
    input  logic                          clk,
    input  logic                          rst,
    input  eth_tx_ctrl_pkg::tx_cmd_t      cmd,
    input  eth_frame_pkg::axis_beat_t     in_beat,
    output eth_frame_pkg::axis_beat_t     shifted,
    output eth_frame_pkg::axis_beat_t     tail,
    output eth_tx_ctrl_pkg::realign_stat_t stat
);

    localparam int NB = eth_frame_pkg::DATA_BYTES;
    localparam int SB = eth_frame_pkg::SHIFT_BYTES;

    eth_frame_pkg::axis_beat_t save_q;

    logic in_end;
    logic save_rem;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            save_q <= '0;
        end else if (cmd.save_in) begin
            save_q <= in_beat;
        end else if (cmd.out_op == eth_tx_ctrl_pkg::OUT_TAIL) begin
            // tail has been sent, nothing left to flush
            save_q.keep <= '0;
        end
    end

    assign in_end   = in_beat.last && (in_beat.keep[NB-1:SB] == '0);
    assign save_rem = (save_q.keep[NB-1:SB] != '0);

    // upper saved bytes move down two lanes, new bytes fill the top
    always_comb begin
        shifted.data = {in_beat.data[8*SB-1:0], save_q.data[8*NB-1:8*SB]};
        shifted.keep = {in_beat.keep[SB-1:0], save_q.keep[NB-1:SB]};
        shifted.last = in_end;
        shifted.user = in_beat.user && in_end;
    end

    always_comb begin
        tail.data = {{(8*SB){1'b0}}, save_q.data[8*NB-1:8*SB]};
        tail.keep = {{SB{1'b0}}, save_q.keep[NB-1:SB]};
        tail.last = save_q.last;
        tail.user = save_q.user;
    end

    assign stat.save_rem      = save_rem;
    assign stat.save_last_rem = save_q.last && save_rem;

endmodule

// File: eth_tx_ctrl_pkg.sv
// transmitter states, datapath command encodings and the control/datapath structs
package eth_tx_ctrl_pkg;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_HDR_LAST,
        ST_HDR_LAST_WAIT,
        ST_PAY_IDLE,
        ST_PAY_XFER,
        ST_PAY_XFER_WAIT,
        ST_PAY_LAST
    } tx_state_e;

    // source for the output register
    typedef enum logic [2:0] {
        OUT_HOLD,
        OUT_HDR_FIRST,
        OUT_HDR_SECOND,
        OUT_SHIFTED,
        OUT_TAIL,
        OUT_FROM_TEMP
    } out_op_e;

    // source for the temp register
    typedef enum logic [1:0] {
        TMP_HOLD,
        TMP_HDR_SECOND,
        TMP_SHIFTED
    } tmp_op_e;

    typedef struct packed {
        logic    store_hdr;
        logic    save_in;
        out_op_e out_op;
        tmp_op_e tmp_op;
    } tx_cmd_t;

    typedef struct packed {
        // saved beat still has bytes above lane 1
        logic save_rem;
        // saved beat is the frame end and needs a tail beat
        logic save_last_rem;
    } realign_stat_t;

endpackage

// File: eth_tx_fsm.sv
// frame sequencing FSM for the 64-bit ethernet transmitter
`timescale 1ns/1ps

module eth_tx_fsm (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          hdr_valid,
    output logic                          hdr_ready,
    input  logic                          in_valid,
    output logic                          in_ready,
    input  logic                          in_last,
    output logic                          out_valid,
    input  logic                          out_ready,
    input  eth_tx_ctrl_pkg::realign_stat_t stat,
    input  logic                          temp_last,
    output logic                          busy,
    output eth_tx_ctrl_pkg::tx_cmd_t      cmd
);

    eth_tx_ctrl_pkg::tx_state_e state_q;
    eth_tx_ctrl_pkg::tx_state_e state_d;
    eth_tx_ctrl_pkg::tx_state_e after_in;

    logic hdr_fire;
    logic in_fire;

    assign hdr_fire = hdr_valid && hdr_ready;
    assign in_fire  = in_valid && in_ready;

    // where to go once a payload beat has been taken
    assign after_in = in_last ? eth_tx_ctrl_pkg::ST_PAY_LAST : eth_tx_ctrl_pkg::ST_PAY_XFER;

    always_comb begin
        state_d       = state_q;
        cmd.store_hdr = 1'b0;
        cmd.save_in   = 1'b0;
        cmd.out_op    = eth_tx_ctrl_pkg::OUT_HOLD;
        cmd.tmp_op    = eth_tx_ctrl_pkg::TMP_HOLD;

        case (state_q)
            eth_tx_ctrl_pkg::ST_IDLE: begin
                if (hdr_fire) begin
                    cmd.store_hdr = 1'b1;
                    cmd.out_op    = eth_tx_ctrl_pkg::OUT_HDR_FIRST;
                    state_d       = eth_tx_ctrl_pkg::ST_HDR_LAST;
                end
            end
            eth_tx_ctrl_pkg::ST_HDR_LAST: begin
                // second header word carries payload bytes 0 and 1
                if (in_fire && out_ready) begin
                    cmd.save_in = 1'b1;
                    cmd.out_op  = eth_tx_ctrl_pkg::OUT_HDR_SECOND;
                    state_d     = after_in;
                end else if (out_ready) begin
                    state_d = eth_tx_ctrl_pkg::ST_HDR_LAST_WAIT;
                end else if (in_fire) begin
                    cmd.save_in = 1'b1;
                    cmd.tmp_op  = eth_tx_ctrl_pkg::TMP_HDR_SECOND;
                    state_d     = eth_tx_ctrl_pkg::ST_PAY_XFER_WAIT;
                end
            end
            eth_tx_ctrl_pkg::ST_HDR_LAST_WAIT: begin
                if (in_fire) begin
                    cmd.save_in = 1'b1;
                    cmd.out_op  = eth_tx_ctrl_pkg::OUT_HDR_SECOND;
                    state_d     = after_in;
                end
            end
            eth_tx_ctrl_pkg::ST_PAY_IDLE: begin
                if (in_fire) begin
                    cmd.save_in = 1'b1;
                    cmd.out_op  = eth_tx_ctrl_pkg::OUT_SHIFTED;
                    state_d     = after_in;
                end
            end
            eth_tx_ctrl_pkg::ST_PAY_XFER: begin
                if (in_fire && out_ready) begin
                    cmd.save_in = 1'b1;
                    cmd.out_op  = eth_tx_ctrl_pkg::OUT_SHIFTED;
                    state_d     = after_in;
                end else if (out_ready) begin
                    state_d = eth_tx_ctrl_pkg::ST_PAY_IDLE;
                end else if (in_fire) begin
                    // output stalled, park the new word in temp
                    cmd.save_in = 1'b1;
                    cmd.tmp_op  = eth_tx_ctrl_pkg::TMP_SHIFTED;
                    state_d     = eth_tx_ctrl_pkg::ST_PAY_XFER_WAIT;
                end
            end
            eth_tx_ctrl_pkg::ST_PAY_XFER_WAIT: begin
                if (out_ready) begin
                    cmd.out_op = eth_tx_ctrl_pkg::OUT_FROM_TEMP;
                    if (temp_last || stat.save_last_rem) begin
                        state_d = eth_tx_ctrl_pkg::ST_PAY_LAST;
                    end else begin
                        state_d = eth_tx_ctrl_pkg::ST_PAY_XFER;
                    end
                end
            end
            eth_tx_ctrl_pkg::ST_PAY_LAST: begin
                if (out_ready) begin
                    if (stat.save_rem) begin
                        // leftover bytes of the final beat go out as a tail
                        cmd.out_op = eth_tx_ctrl_pkg::OUT_TAIL;
                    end else begin
                        state_d = eth_tx_ctrl_pkg::ST_IDLE;
                    end
                end
            end
            default: begin
                state_d = eth_tx_ctrl_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q   <= eth_tx_ctrl_pkg::ST_IDLE;
            hdr_ready <= 1'b0;
            in_ready  <= 1'b0;
            out_valid <= 1'b0;
            busy      <= 1'b0;
        end else begin
            state_q   <= state_d;
            busy      <= (state_d != eth_tx_ctrl_pkg::ST_IDLE);
            hdr_ready <= (state_d == eth_tx_ctrl_pkg::ST_IDLE);
            in_ready  <= (state_d == eth_tx_ctrl_pkg::ST_HDR_LAST) ||
                         (state_d == eth_tx_ctrl_pkg::ST_HDR_LAST_WAIT) ||
                         (state_d == eth_tx_ctrl_pkg::ST_PAY_IDLE) ||
                         (state_d == eth_tx_ctrl_pkg::ST_PAY_XFER);
            out_valid <= (state_d == eth_tx_ctrl_pkg::ST_HDR_LAST) ||
                         (state_d == eth_tx_ctrl_pkg::ST_PAY_XFER) ||
                         (state_d == eth_tx_ctrl_pkg::ST_PAY_XFER_WAIT) ||
                         (state_d == eth_tx_ctrl_pkg::ST_PAY_LAST);
        end
    end

    // a new header is never taken while payload of the current frame is open
    a_ready_excl: assert property (@(posedge clk) disable iff (rst)
        !(hdr_ready && in_ready));

    // a presented output word is held until the sink takes it
    a_valid_hold: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> out_valid);

endmodule

// File: eth_tx_out_stage.sv
// output register plus temp register that together absorb output stalls
`timescale 1ns/1ps

module eth_tx_out_stage (
    input  logic                     clk,
    input  logic                     rst,
    input  eth_tx_ctrl_pkg::tx_cmd_t cmd,
    input  eth_frame_pkg::axis_beat_t hdr_first,
    input  eth_frame_pkg::axis_beat_t hdr_second,
    input  eth_frame_pkg::axis_beat_t shifted,
    input  eth_frame_pkg::axis_beat_t tail,
    output eth_frame_pkg::axis_beat_t out_beat,
    output logic                     temp_last
);

    eth_frame_pkg::axis_beat_t out_q;
    eth_frame_pkg::axis_beat_t temp_q;

    logic out_takes_in;
    logic temp_takes_in;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_q <= '0;
        end else begin
            case (cmd.out_op)
                eth_tx_ctrl_pkg::OUT_HDR_FIRST:  out_q <= hdr_first;
                eth_tx_ctrl_pkg::OUT_HDR_SECOND: out_q <= hdr_second;
                eth_tx_ctrl_pkg::OUT_SHIFTED:    out_q <= shifted;
                eth_tx_ctrl_pkg::OUT_TAIL:       out_q <= tail;
                eth_tx_ctrl_pkg::OUT_FROM_TEMP:  out_q <= temp_q;
                default: begin
                    out_q <= out_q;
                end
            endcase
        end
    end

    // temp only fills while the output word is stalled
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            temp_q <= '0;
        end else begin
            case (cmd.tmp_op)
                eth_tx_ctrl_pkg::TMP_HDR_SECOND: temp_q <= hdr_second;
                eth_tx_ctrl_pkg::TMP_SHIFTED:    temp_q <= shifted;
                default: begin
                    temp_q <= temp_q;
                end
            endcase
        end
    end

    assign out_beat  = out_q;
    assign temp_last = temp_q.last;

    assign out_takes_in = (cmd.out_op == eth_tx_ctrl_pkg::OUT_HDR_SECOND) ||
                          (cmd.out_op == eth_tx_ctrl_pkg::OUT_SHIFTED);
    assign temp_takes_in = (cmd.tmp_op != eth_tx_ctrl_pkg::TMP_HOLD);

    // one input beat lands in exactly one register
    a_single_dest: assert property (@(posedge clk) disable iff (rst)
        !(out_takes_in && temp_takes_in));

endmodule

// File: list.f
eth_frame_pkg.sv
eth_tx_ctrl_pkg.sv
eth_tx_fsm.sv
eth_hdr_builder.sv
eth_payload_realign.sv
eth_tx_out_stage.sv
eth_axis_tx_64.sv
tb_eth_axis_tx_64.sv

// File: tb_eth_axis_tx_64.sv
// testbench with lfsr stimulus, reference byte model and stream assertions for the transmitter
`timescale 1ns/1ps

module tb_eth_axis_tx_64;

    localparam int WAIT_LIMIT = 400;

    logic                      clk = 1'b0;
    logic                      rst;
    eth_frame_pkg::eth_hdr_t   hdr;
    logic                      hdr_valid;
    logic                      hdr_ready;
    eth_frame_pkg::axis_beat_t in_beat;
    logic                      in_valid;
    logic                      in_ready;
    eth_frame_pkg::axis_beat_t out_beat;
    logic                      out_valid;
    logic                      out_ready;
    logic                      busy;

    // expected wire bytes packed as {user, frame end, byte}
    logic [9:0]  exp_q[$];
    logic [63:0] exp_data;
    logic [63:0] exp_mask;
    logic [7:0]  exp_keep;
    logic        exp_last;
    logic        exp_user;
    int          exp_count;

    logic [31:0] lfsr;
    logic        stall_en;
    logic        gap_en;
    logic        xfer_q;
    logic        frame_open;
    string       test_name;

    eth_axis_tx_64 UUT (
        .clk       (clk),
        .rst       (rst),
        .hdr       (hdr),
        .hdr_valid (hdr_valid),
        .hdr_ready (hdr_ready),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .busy      (busy)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            // fibonacci taps 32 22 2 1
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [31:0] r;
        r = rand_bits(8);
        return r[7:0];
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    // advance one cycle and draw a fresh out_ready
    task automatic tick();
        @(negedge clk);
        if (stall_en) begin
            out_ready = (rand_bits(2) != 32'd0);
        end else begin
            out_ready = 1'b1;
        end
    endtask

    // hold the offer until ready is seen and cross the accepting edge
    task automatic offer_until_taken(input bit is_hdr, input string what);
        int n;
        n = 0;
        while (!(is_hdr ? hdr_ready : in_ready)) begin
            tick();
            n++;
            if (n > WAIT_LIMIT) begin
                stop_on_error({"timeout waiting for ", what});
            end
        end
        tick();
    endtask

    task automatic send_frame(input int len);
        logic [111:0]              hbits;
        logic [7:0]                pay[$];
        eth_frame_pkg::axis_beat_t beat;
        logic                      user;
        logic                      fin;
        int                        nb;
        for (int i = 0; i < 14; i++) begin
            hbits = {hbits[103:0], rand_byte()};
        end
        user = (rand_bits(1) != 32'd0);
        // destination, source and ethertype leave most significant byte first
        for (int i = 13; i >= 0; i--) begin
            exp_q.push_back({2'b00, hbits[8*i +: 8]});
        end
        for (int i = 0; i < len; i++) begin
            pay.push_back(rand_byte());
            fin = (i == len - 1);
            exp_q.push_back({user && fin, fin, pay[i]});
        end
        if (gap_en) begin
            repeat (rand_bits(2)) tick();
        end
        hdr       = hbits;
        hdr_valid = 1'b1;
        offer_until_taken(1'b1, "hdr_ready");
        hdr_valid = 1'b0;
        nb = (len + 7) / 8;
        for (int b = 0; b < nb; b++) begin
            if (gap_en) begin
                repeat (rand_bits(2)) tick();
            end
            for (int k = 0; k < 8; k++) begin
                beat.keep[k] = (8*b + k < len);
                if (8*b + k < len) begin
                    beat.data[8*k +: 8] = pay[8*b + k];
                end else begin
                    beat.data[8*k +: 8] = rand_byte();
                end
            end
            beat.last = (b == nb - 1);
            // user on earlier beats must not reach the output
            beat.user = beat.last ? user : (rand_bits(1) != 32'd0);
            in_beat   = beat;
            in_valid  = 1'b1;
            offer_until_taken(1'b0, "in_ready");
            in_valid = 1'b0;
        end
    endtask

    always @(posedge clk) begin
        xfer_q <= !rst && out_valid && out_ready;
    end

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            frame_open <= 1'b0;
        end else if (hdr_valid && hdr_ready) begin
            frame_open <= 1'b1;
        end else if (out_valid && out_ready && out_beat.last) begin
            frame_open <= 1'b0;
        end
    end

    // drop the bytes of the beat just taken and look ahead to the next beat
    always @(negedge clk) begin
        if (xfer_q) begin
            for (int i = 0; i < exp_count; i++) begin
                void'(exp_q.pop_front());
            end
        end
        exp_data  = '0;
        exp_mask  = '0;
        exp_keep  = '0;
        exp_last  = 1'b0;
        exp_user  = 1'b0;
        exp_count = 0;
        while (exp_count < 8 && exp_count < exp_q.size() && !exp_last) begin
            exp_data[8*exp_count +: 8] = exp_q[exp_count][7:0];
            exp_mask[8*exp_count +: 8] = 8'hff;
            exp_keep[exp_count]        = 1'b1;
            exp_last                   = exp_q[exp_count][8];
            exp_user                   = exp_q[exp_count][9];
            exp_count++;
        end
    end

    a_reset_quiet: assert property (@(posedge clk)
        rst |-> (!out_valid && !in_ready && !hdr_ready && !busy))
        else stop_on_error("handshake outputs or busy high during reset");

    a_have_bytes: assert property (@(posedge clk) disable iff (rst)
        (out_valid && out_ready) |-> (exp_count != 0))
        else stop_on_error("output beat accepted with no expected bytes left");

    a_data: assert property (@(posedge clk) disable iff (rst)
        (out_valid && out_ready) |-> (((out_beat.data ^ exp_data) & exp_mask) == '0))
        else stop_on_error($sformatf("FAILED %s data expected %h actual %h", test_name,
            exp_data, $sampled(out_beat.data) & exp_mask));

    a_keep: assert property (@(posedge clk) disable iff (rst)
        (out_valid && out_ready) |-> (out_beat.keep == exp_keep))
        else stop_on_error($sformatf("FAILED %s keep expected %h actual %h", test_name,
            exp_keep, $sampled(out_beat.keep)));

    a_last: assert property (@(posedge clk) disable iff (rst)
        (out_valid && out_ready) |-> (out_beat.last == exp_last))
        else stop_on_error($sformatf("FAILED %s last expected %b actual %b", test_name,
            exp_last, $sampled(out_beat.last)));

    a_user: assert property (@(posedge clk) disable iff (rst)
        (out_valid && out_ready) |-> (out_beat.user == exp_user))
        else stop_on_error($sformatf("FAILED %s user expected %b actual %b", test_name,
            exp_user, $sampled(out_beat.user)));

    a_stall_hold: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_beat)))
        else stop_on_error("out_beat changed or out_valid fell while the output was stalled");

    a_busy: assert property (@(posedge clk) disable iff (rst)
        busy == frame_open)
        else stop_on_error($sformatf("FAILED %s busy expected %b actual %b", test_name,
            $sampled(frame_open), $sampled(busy)));

    a_no_hdr_in_frame: assert property (@(posedge clk) disable iff (rst)
        frame_open |-> !hdr_ready)
        else stop_on_error("hdr_ready high while a frame was still open");

    a_quiet_outside_frame: assert property (@(posedge clk) disable iff (rst)
        (in_ready || out_valid) |-> frame_open)
        else stop_on_error("in_ready or out_valid high outside a frame");

    initial begin
        int n;
        lfsr      = 32'h7d36_ec01;
        rst       = 1'b1;
        hdr       = '0;
        hdr_valid = 1'b0;
        in_beat   = '0;
        in_valid  = 1'b0;
        out_ready = 1'b0;
        stall_en  = 1'b0;
        gap_en    = 1'b0;
        test_name = "reset";
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        n = 0;
        while (!hdr_ready) begin
            tick();
            n++;
            if (n > WAIT_LIMIT) begin
                stop_on_error("hdr_ready never rose after reset");
            end
        end
        a_idle: assert (!out_valid && !in_ready && !busy)
            else stop_on_error("outputs not idle after reset release");
        // lengths 1 to 24 end in every lane and some need a tail beat
        for (int len = 1; len <= 24; len++) begin
            test_name = $sformatf("directed_len%0d", len);
            send_frame(len);
        end
        stall_en = 1'b1;
        gap_en   = 1'b1;
        for (int f = 0; f < 60; f++) begin
            test_name = $sformatf("random_frame%0d", f);
            send_frame(1 + int'(rand_bits(5) % 24));
        end
        n = 0;
        while (frame_open || exp_q.size() != 0) begin
            tick();
            n++;
            if (n > WAIT_LIMIT) begin
                stop_on_error("final frame never completed");
            end
        end
        repeat (2) tick();
        if (exp_q.size() == 0 && !frame_open && !busy) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            stop_on_error("bytes left over after the final frame");
        end
    end

endmodule
